// File: hw/ts_pkg.sv
/* timestamp capture types and constants */

package ts_pkg;

    typedef logic [31:0] sec_t;          // seconds count, wraps at 2^32
    typedef logic [19:0] usec_t;         // microseconds, 0..999999
    typedef logic [7:0]  ts_byte_t;      // one byte on the ts bus
    typedef logic [2:0]  ts_idx_t;       // byte index inside a message

    // usec in the upper field, sec in the lower one, 52 bits
    typedef struct packed {
        usec_t usec;                     // bits 51:32
        sec_t  sec;                      // bits 31:0
    } timestamp_t;

    localparam usec_t USEC_MAX = 20'd999_999;   // last value before sec carry

    // tclk cycles per microsecond, kept small for short sims
    localparam int USEC_DIV = 4;
    localparam int PRESC_W  = $clog2(USEC_DIV); // prescaler width

    // extra synchronizer stages in the snap crossing
    localparam int CROSS_EXTRA_DLY = 1;
    localparam int CROSS_STAGES    = 2 + CROSS_EXTRA_DLY;

    localparam int TS_BYTES = 8;                // bytes per message
    localparam int TS_W     = $bits(timestamp_t);
    localparam int MSG_W    = TS_BYTES * 8;     // full message width

endpackage

// File: hw/rtc_counter.sv
/* real-time clock counter */
`timescale 1ns/10ps

module rtc_counter import ts_pkg::*; (
    input  logic       tclk,          // time counter clock
    input  logic       srst,          // sclk domain reset, resynced below
    input  logic       time_load,     // @tclk load strobe
    input  timestamp_t load_time,     // @tclk new time value
    output timestamp_t now            // @tclk running time
);

    logic [1:0]         rst_sync;     // srst into tclk
    logic               rst_t;        // local reset
    logic [PRESC_W-1:0] presc;        // microsecond prescaler
    logic               usec_tick;    // last prescaler cycle
    logic               usec_wrap;    // usec at its top value

    always_ff @(posedge tclk) begin
        rst_sync <= {rst_sync[0], srst};    // two flop resync
    end

    assign rst_t     = rst_sync[1];
    assign usec_tick = (presc == PRESC_W'(USEC_DIV - 1));
    assign usec_wrap = (now.usec == USEC_MAX);

    always_ff @(posedge tclk) begin
        if (rst_t) begin
            presc <= '0;
            now   <= '0;                    // time starts at zero
        end else if (time_load) begin
            presc <= '0;                    // restart the microsecond
            now   <= load_time;
        end else begin
            if (usec_tick) begin
                presc <= '0;
            end else begin
                presc <= presc + 1'b1;
            end

            if (usec_tick) begin
                if (usec_wrap) begin
                    now.usec <= '0;
                    now.sec  <= now.sec + 1'b1; // rolls over at 2^32
                end else begin
                    now.usec <= now.usec + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/pulse_cross_clock.sv
/* toggle based pulse crossing */
`timescale 1ns/10ps

module pulse_cross_clock import ts_pkg::*; (
    input  logic srst,               // @src_clk sync reset
    input  logic src_clk,
    input  logic dst_clk,
    input  logic in_pulse,           // @src_clk single cycle pulse
    output logic out_pulse,          // @dst_clk single cycle pulse
    output logic busy                // @src_clk crossing in flight
);

    logic                    src_tgl;   // flips once per accepted pulse
    logic [CROSS_STAGES-1:0] dst_sync;  // toggle into dst_clk
    logic [1:0]              ack_sync;  // last dst stage back to src

    // src side: toggle and acknowledge resync
    always_ff @(posedge src_clk) begin
        if (srst) begin
            src_tgl  <= 1'b0;
            ack_sync <= '0;
        end else begin
            if (in_pulse && !busy) begin
                src_tgl <= ~src_tgl;            // pulses while busy are dropped
            end
            ack_sync <= {ack_sync[0], dst_sync[CROSS_STAGES-1]};
        end
    end

    // dst side settles to the idle toggle level while srst is held
    always_ff @(posedge dst_clk) begin
        dst_sync <= {dst_sync[CROSS_STAGES-2:0], src_tgl};
    end

    // edge of the two last stages gives one dst cycle
    assign out_pulse = dst_sync[CROSS_STAGES-1] ^ dst_sync[CROSS_STAGES-2];

    // high until the ack has come back round
    assign busy = src_tgl ^ ack_sync[1];

endmodule

// File: hw/timestamp_snapshot.sv
/* timestamp snapshot and byte serializer */
`timescale 1ns/10ps

module timestamp_snapshot import ts_pkg::*; (
    input  logic       tclk,          // time counter clock
    input  timestamp_t now,           // @tclk current time
    input  logic       sclk,          // system clock
    input  logic       srst,          // @sclk sync reset
    input  logic       snap,          // @sclk snapshot strobe
    output logic       pre_stb,       // one cycle ahead of the bytes
    output ts_byte_t   ts_data        // s0..s3, u0..u2, zero
);

    logic             snap_tclk;      // crossed strobe in tclk
    logic             pulse_busy;     // crossing in flight
    logic             busy_r;         // busy, one cycle late
    logic             pre_stb_w;      // busy just fell
    logic             snd;            // bytes going out
    logic             last_byte;      // index at the final byte
    timestamp_t       snap_reg;       // captured time
    ts_idx_t          idx;            // current byte index
    logic [MSG_W-1:0] msg;            // padded message word

    pulse_cross_clock snap_cross (
        .srst      (srst),
        .src_clk   (sclk),
        .dst_clk   (tclk),
        .in_pulse  (snap),
        .out_pulse (snap_tclk),
        .busy      (pulse_busy)
    );

    // capture in the counter domain
    always_ff @(posedge tclk) begin
        if (snap_tclk) begin
            snap_reg <= now;
        end
    end

    // snap_reg is stable once the ack is back in sclk
    assign pre_stb_w = busy_r && !pulse_busy;
    assign last_byte = (idx == ts_idx_t'(TS_BYTES - 1));

    // usec top nibble and the last byte padded with zeros
    assign msg = {{(MSG_W - TS_W){1'b0}}, snap_reg};

    always_ff @(posedge sclk) begin
        if (srst) begin
            busy_r  <= 1'b0;
            pre_stb <= 1'b0;
            snd     <= 1'b0;                 // not sending after reset
            idx     <= '0;
        end else begin
            busy_r  <= pulse_busy;
            pre_stb <= pre_stb_w;
            if (pre_stb_w) begin
                snd <= 1'b1;
            end else if ((snd && last_byte) || snap) begin
                snd <= 1'b0;                 // done, or a new snap cuts in
            end
            idx <= snd ? idx + 1'b1 : '0;
        end
    end

    // bus holds its last byte between messages
    always_ff @(posedge sclk) begin
        if (snd) begin
            ts_data <= msg[{idx, 3'b000} +: 8];
        end
    end

endmodule

// File: hw/ts_message_receiver.sv
/* timestamp message receiver */
`timescale 1ns/10ps

module ts_message_receiver import ts_pkg::*; (
    input  logic       sclk,
    input  logic       srst,          // sync reset
    input  logic       pre_stb,       // message start marker
    input  ts_byte_t   ts_data,       // message bytes
    output logic       ts_valid,      // ts_out just updated
    output timestamp_t ts_out         // reassembled time
);

    typedef enum logic [1:0] {
        st_idle,                      // waiting for pre_stb
        st_wait_first,                // pre_stb seen, byte 0 on the bus
        st_collect                    // bytes 1..7
    } rx_state_t;

    rx_state_t        state;
    ts_idx_t          idx;            // index of the byte on the bus
    logic [MSG_W-1:0] asm_reg;        // assembly register
    logic [MSG_W-1:0] asm_next;       // with the current byte placed
    logic             msg_done;       // last byte this cycle

    always_comb begin
        asm_next = asm_reg;
        asm_next[{idx, 3'b000} +: 8] = ts_data;
    end

    assign msg_done = (state == st_collect) && (idx == ts_idx_t'(TS_BYTES - 1));

    always_ff @(posedge sclk) begin
        if (srst) begin
            state    <= st_idle;
            idx      <= '0;
            ts_valid <= 1'b0;
        end else begin
            ts_valid <= msg_done;
            if (pre_stb) begin
                state <= st_wait_first;      // restart on every marker
                idx   <= '0;
            end else begin
                case (state)
                    st_wait_first: begin
                        state <= st_collect;
                        idx   <= idx + 1'b1;
                    end
                    st_collect: begin
                        if (msg_done) begin
                            state <= st_idle;
                        end
                        idx <= idx + 1'b1;   // wraps to 0 after byte 7
                    end
                    default: begin
                        state <= st_idle;
                        idx   <= '0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (state != st_idle) begin
            asm_reg <= asm_next;
        end
        if (msg_done) begin
            ts_out <= timestamp_t'(asm_next[TS_W-1:0]);  // padding dropped
        end
    end

endmodule

// File: hw/ts_snapshot_top.sv
/* timestamp capture top */
`timescale 1ns/10ps

module ts_snapshot_top import ts_pkg::*; (
    // time counter domain
    input  logic       tclk,
    input  logic       time_load,     // load strobe
    input  timestamp_t load_time,     // time to load
    // system domain
    input  logic       sclk,
    input  logic       srst,          // sync reset
    input  logic       snap,          // snapshot strobe
    output logic       pre_stb,       // message start marker
    output ts_byte_t   ts_data,       // message bytes
    output logic       ts_valid,      // timestamp ready
    output timestamp_t ts_out         // received timestamp
);

    timestamp_t now;                  // @tclk running time

    rtc_counter rtc0 (
        .tclk      (tclk),
        .srst      (srst),
        .time_load (time_load),
        .load_time (load_time),
        .now       (now)
    );

    timestamp_snapshot snap0 (
        .tclk    (tclk),
        .now     (now),
        .sclk    (sclk),
        .srst    (srst),
        .snap    (snap),
        .pre_stb (pre_stb),
        .ts_data (ts_data)
    );

    ts_message_receiver rx0 (
        .sclk     (sclk),
        .srst     (srst),
        .pre_stb  (pre_stb),
        .ts_data  (ts_data),
        .ts_valid (ts_valid),
        .ts_out   (ts_out)
    );

endmodule

// File: test/tb_ts_snapshot.sv
/* timestamp capture testbench */
`timescale 1ns/10ps

module tb_ts_snapshot import ts_pkg::*; ();

    localparam int SNAPS      = 40;          // snapshots per run
    localparam int SCLK_PER   = 8;           // ns
    localparam int TCLK_PER   = 10;          // ns
    localparam int RST_CYCLES = 10;          // srst length in sclk cycles
    localparam int PRE_LIMIT  = 100;         // sclk cycles allowed from snap to pre_stb
    localparam int SEED       = 32'hdfd7;

    logic       sclk;
    logic       tclk;
    logic       srst;
    logic       snap;
    logic       time_load;
    timestamp_t load_time;
    logic       pre_stb;
    ts_byte_t   ts_data;
    logic       ts_valid;
    timestamp_t ts_out;

    // reference time, stepped on every tclk edge
    sec_t  m_sec;
    usec_t m_usec;
    int    m_presc;                          // tclk edges inside the microsecond

    timestamp_t  start_time;                 // loaded once after reset
    logic [63:0] prev_total;                 // last timestamp in microseconds
    int          pre_cnt;                    // pre_stb pulses seen
    int          valid_cnt;                  // ts_valid pulses seen
    int          seed_ret;
    int          i;
    logic        saw_before_wrap;            // a ts with the loaded sec
    logic        saw_after_wrap;             // a ts with sec + 1

    ts_snapshot_top dut0 (
        .tclk      (tclk),
        .time_load (time_load),
        .load_time (load_time),
        .sclk      (sclk),
        .srst      (srst),
        .snap      (snap),
        .pre_stb   (pre_stb),
        .ts_data   (ts_data),
        .ts_valid  (ts_valid),
        .ts_out    (ts_out)
    );

    always #(SCLK_PER / 2) sclk = ~sclk;
    always #(TCLK_PER / 2) tclk = ~tclk;     // rising edges never meet sclk edges

    // counter rule: load wins, else one usec per USEC_DIV edges
    always @(posedge tclk) begin
        if (time_load) begin
            m_sec   = load_time.sec;
            m_usec  = load_time.usec;
            m_presc = 0;                     // microsecond restarts
        end else if (m_presc == USEC_DIV - 1) begin
            m_presc = 0;
            if (m_usec == USEC_MAX) begin
                m_usec = '0;
                m_sec  = m_sec + 32'd1;      // seconds carry
            end else begin
                m_usec = m_usec + 20'd1;
            end
        end else begin
            m_presc = m_presc + 1;
        end
    end

    // pulse counters for the whole run
    always @(negedge sclk) begin
        if (!srst) begin
            if (pre_stb === 1'b1) begin
                pre_cnt = pre_cnt + 1;
            end
            if (ts_valid === 1'b1) begin
                valid_cnt = valid_cnt + 1;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run($sformatf("%s does not hold the expected value", name));
        end
    endtask

    function automatic logic [63:0] to_usec(input sec_t s, input usec_t u);
        return 64'(s) * 64'd1_000_000 + 64'(u);     // microseconds since zero
    endfunction

    // quiet bus while no snap is pending
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge sclk);
            check_value("pre_stb", 64'(pre_stb), 64'd0);
            check_value("ts_valid", 64'(ts_valid), 64'd0);
        end
    endtask

    task automatic run_snapshot();
        logic [63:0] lower;
        logic [63:0] upper;
        logic [63:0] ts_total;
        logic [63:0] got_msg;
        logic [63:0] exp_msg;
        sec_t        lo_sec;
        sec_t        hi_sec;
        int          wait_cnt;
        int          k;

        @(posedge sclk);
        snap   <= 1'b1;
        lower  = to_usec(m_sec, m_usec);     // nothing captured before this
        lo_sec = m_sec;
        @(posedge sclk);
        snap <= 1'b0;

        wait_cnt = 0;
        @(negedge sclk);
        while (pre_stb !== 1'b1) begin
            if (wait_cnt == PRE_LIMIT) begin
                abort_run("pre_stb never came after a snap");
            end
            check_value("ts_valid", 64'(ts_valid), 64'd0);
            wait_cnt = wait_cnt + 1;
            @(negedge sclk);
        end
        upper  = to_usec(m_sec, m_usec);     // capture is already done here
        hi_sec = m_sec;

        // byte k shows up k+1 cycles after pre_stb
        got_msg = '0;
        for (k = 0; k < TS_BYTES; k++) begin
            @(negedge sclk);
            got_msg = {ts_data, got_msg[63:8]};
            check_value("pre_stb", 64'(pre_stb), 64'd0);
            check_value("ts_valid", 64'(ts_valid), 64'd0);
        end
        @(negedge sclk);
        check_value("ts_valid", 64'(ts_valid), 64'd1);  // 9 cycles after pre_stb
        check_value("pre_stb", 64'(pre_stb), 64'd0);

        ts_total = to_usec(ts_out.sec, ts_out.usec);
        check_value($sformatf("ts_out.usec 0x%0h within USEC_MAX", ts_out.usec),
                    64'(ts_out.usec <= USEC_MAX), 64'd1);
        check_value($sformatf("ts_out 0x%0h above lower 0x%0h", ts_total, lower),
                    64'(ts_total >= lower), 64'd1);
        check_value($sformatf("ts_out 0x%0h below upper 0x%0h", ts_total, upper),
                    64'(ts_total <= upper), 64'd1);
        check_value($sformatf("ts_out 0x%0h after previous 0x%0h", ts_total, prev_total),
                    64'(ts_total >= prev_total), 64'd1);
        if (lo_sec == hi_sec) begin
            check_value("ts_out.sec", 64'(ts_out.sec), 64'(lo_sec));
        end
        if (ts_out.sec == start_time.sec) begin
            saw_before_wrap = 1'b1;
        end
        if (ts_out.sec == start_time.sec + 32'd1) begin
            saw_after_wrap = 1'b1;
        end
        prev_total = ts_total;

        // sec bytes, usec bytes with a zero top nibble, zero byte
        exp_msg = {8'h00, 4'h0, ts_out.usec, ts_out.sec};
        for (k = 0; k < TS_BYTES; k++) begin
            check_value($sformatf("ts_data byte %0d", k),
                        64'(ts_byte_t'(got_msg >> (8 * k))),
                        64'(ts_byte_t'(exp_msg >> (8 * k))));
        end
        check_value("ts_data byte 7", 64'(got_msg[63:56]), 64'd0);
        check_value("ts_data byte 6 upper nibble", 64'(got_msg[55:52]), 64'd0);
    endtask

    // watchdog, 200 sclk periods per snapshot plus reset
    initial begin
        #((SNAPS * 200 + RST_CYCLES) * SCLK_PER);
        abort_run("watchdog expired before all snapshots were received");
    end

    initial begin
        sclk            = 1'b0;
        tclk            = 1'b0;
        srst            = 1'b1;
        snap            = 1'b0;
        time_load       = 1'b0;
        load_time       = '0;
        m_sec           = '0;
        m_usec          = '0;
        m_presc         = 0;
        prev_total      = '0;
        pre_cnt         = 0;
        valid_cnt       = 0;
        saw_before_wrap = 1'b0;
        saw_after_wrap  = 1'b0;
        seed_ret        = $urandom(SEED);

        // sec kept below 2^31, usec wraps a few microseconds in
        start_time.sec  = sec_t'($urandom) & 32'h7fff_ffff;
        start_time.usec = USEC_MAX - usec_t'(20 + $urandom % 60);

        repeat (RST_CYCLES) @(posedge sclk);
        srst <= 1'b0;
        repeat (4) @(posedge tclk);          // tclk side out of reset
        time_load <= 1'b1;
        load_time <= start_time;
        @(posedge tclk);
        time_load <= 1'b0;

        idle_cycles(20);
        for (i = 0; i < SNAPS; i++) begin
            run_snapshot();
            idle_cycles(int'($urandom % 41));
        end
        idle_cycles(2);                      // let the counters settle

        check_value("pre_stb pulses", 64'(pre_cnt), 64'(SNAPS));
        check_value("ts_valid pulses", 64'(valid_cnt), 64'(SNAPS));
        check_value("sec wrap seen", 64'({saw_before_wrap, saw_after_wrap}), 64'd3);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: flist.f
hw/ts_pkg.sv
hw/rtc_counter.sv
hw/pulse_cross_clock.sv
hw/timestamp_snapshot.sv
hw/ts_message_receiver.sv
hw/ts_snapshot_top.sv
test/tb_ts_snapshot.sv

// File: Makefile
# Verilator flow for the timestamp capture subsystem

VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_ts_snapshot
RTL_TOP   ?= ts_snapshot_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
BFLAGS    ?= -Wno-fatal

PASS_MSG := *** PASSED ***
FAIL_MSG := *** FAILED ***
SRCS     := $(shell grep -v '^+' $(FLIST))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) $(BFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
